// File: files.f
verilog/io_pkg.sv
verilog/uart_if.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/program_loader.sv
verilog/image_sender.sv
verilog/io_control.sv
verilog/io_top.sv
verification/tb_clock.sv
verification/io_chk.sv
verification/io_monitor.sv
verification/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and scan the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --timescale 1ns/100ps \
  --top-module tb_top \
  -f files.f \
  -o tb_top_sim

obj_dir/tb_top_sim +verilator+error+limit+100 | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
  exit 1
fi
exit 0

// File: verification/io_chk.sv
`default_nettype none

module io_chk (
  input logic clk,
  input logic rstn,
  input logic pulse,
  input logic pulse_ok,
  input logic req,
  input logic req_ok
);
  timeunit 1ns;
  timeprecision 100ps;

  int fail_cnt = 0;

  a_pulse_short: assert property (@(posedge clk) disable iff (!rstn) pulse |=> !pulse)
    else begin
      $error("pulse high for more than one cycle");
      fail_cnt++;
    end

  a_pulse_allowed: assert property (@(posedge clk) disable iff (!rstn) pulse |-> pulse_ok)
    else begin
      $error("pulse outside its enabling condition");
      fail_cnt++;
    end

  a_req_allowed: assert property (@(posedge clk) disable iff (!rstn) req |-> req_ok)
    else begin
      $error("request while its target was not ready");
      fail_cnt++;
    end

endmodule

`default_nettype wire

// File: verification/io_monitor.sv
`default_nettype none

module io_monitor import io_pkg::*; #(
  parameter int HALF = 4,
  parameter word_t IMG_BASE = '0,
  parameter int N_PROG = 4,
  parameter int N_PIX = 6
) (
  input logic clk,
  input logic rstn,
  input logic txd,
  input logic wr_en_instr,
  input word_t addr_in_instr,
  input word_t data_in_instr,
  input logic memread_io,
  input word_t addr_io,
  input logic core_start,
  input logic core_end,
  input word_t prog_words [N_PROG],
  input logic [95:0] pix_lines [N_PIX]
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_BYTES = 17 + 12 * N_PIX;  // two syncs, header, pixel lines
  localparam logic [119:0] HEADER = "P3\n003 002 255\n";

  int err_cnt = 0;
  int err_mark = 0;
  int test_cnt = 0;
  int bad_cnt = 0;
  int tx_cnt = 0;
  int wr_cnt = 0;
  int rd_cnt = 0;
  logic start_seen = 1'b0;
  logic start_lost = 1'b0;
  logic end_seen = 1'b0;
  logic done = 1'b0;

  function automatic logic [7:0] expected_byte(input int n);
    if (n == 0) return 8'h99;
    if (n == 1) return 8'haa;
    if (n < 17) return HEADER[8 * (16 - n) +: 8];
    return pix_lines[(n - 17) / 12][8 * (11 - (n - 17) % 12) +: 8];
  endfunction

  task automatic value_error(input string sig, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
    $display("[FAIL] at %0d ns %s: expected 0x%0h, got 0x%0h", $time, sig, exp_v, act_v);
    err_cnt++;
  endtask

  task automatic plain_error(input string what);
    $display("error at %0d ns: %s", $time, what);
    err_cnt++;
  endtask

  task automatic close_test(input string name);
    test_cnt++;
    if (err_cnt == err_mark) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      bad_cnt++;
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - err_mark);
    end
    err_mark = err_cnt;
  endtask

  task automatic check_byte(input logic [7:0] b);
    if (tx_cnt >= N_BYTES) begin
      plain_error($sformatf("extra txd byte 0x%0h after the last pixel line", b));
      return;
    end
    if (b !== expected_byte(tx_cnt)) begin
      value_error($sformatf("txd byte %0d", tx_cnt), expected_byte(tx_cnt), b);
    end
    if (tx_cnt == 0) close_test("reset state and load sync");
    else if (tx_cnt == 1) close_test("core start and run sync");
    else if (tx_cnt == 16) close_test("ppm header");
    else if (tx_cnt > 16 && (tx_cnt - 17) % 12 == 11) begin
      close_test($sformatf("pixel %0d", (tx_cnt - 17) / 12));
    end
  endtask

  initial begin : reset_check
    @(posedge clk);
    while (!rstn) @(posedge clk);
    if (txd !== 1'b1) value_error("txd", 1, txd);
    if (core_start !== 1'b0) value_error("core_start", 0, core_start);
    if (wr_en_instr !== 1'b0) value_error("wr_en_instr", 0, wr_en_instr);
    if (memread_io !== 1'b0) value_error("memread_io", 0, memread_io);
  end

  initial begin : txd_decoder
    logic [7:0] b;
    forever begin
      @(posedge clk);
      if (rstn && txd === 1'b0) begin
        if (tx_cnt >= 2 && !end_seen) plain_error("txd byte started before core_end");
        repeat (HALF) @(posedge clk);  // middle of start bit
        for (int i = 0; i < 8; i++) begin
          repeat (2 * HALF) @(posedge clk);
          b[i] = txd;
        end
        repeat (2 * HALF) @(posedge clk);
        if (txd !== 1'b1) plain_error("txd stop bit is low");
        check_byte(b);
        tx_cnt++;
      end
    end
  end

  initial begin : port_checks
    forever begin
      @(posedge clk);
      if (rstn) begin
        if (wr_en_instr) begin
          if (wr_cnt >= N_PROG) begin
            plain_error("instruction write after the last program word");
          end else begin
            if (addr_in_instr !== 32'(4 * wr_cnt)) begin
              value_error("addr_in_instr", 32'(4 * wr_cnt), addr_in_instr);
            end
            if (data_in_instr !== prog_words[wr_cnt]) begin
              value_error("data_in_instr", prog_words[wr_cnt], data_in_instr);
            end
          end
          wr_cnt++;
          if (wr_cnt == N_PROG) close_test("program writes");
        end
        if (start_seen && !core_start && !start_lost) begin
          start_lost = 1'b1;
          plain_error("core_start dropped after it rose");
        end
        if (!start_seen && core_start) begin
          start_seen = 1'b1;
          if (wr_cnt != N_PROG) plain_error("core_start rose before the last program write");
        end
        if (core_end && !end_seen) begin
          end_seen = 1'b1;
          close_test("idle until core_end");
        end
        if (memread_io) begin
          if (!end_seen) plain_error("memread_io before core_end");
          if (rd_cnt >= N_PIX) begin
            plain_error("memory read after the last pixel");
          end else begin
            if (addr_io !== IMG_BASE + 32'(4 * rd_cnt)) begin
              value_error("addr_io", IMG_BASE + 32'(4 * rd_cnt), addr_io);
            end
            if (tx_cnt != 17 + 12 * rd_cnt) plain_error("pixel fetched before last line ended");
          end
          rd_cnt++;
        end
      end
    end
  end

  initial begin : trailing_check
    wait (tx_cnt == N_BYTES);
    repeat (4 * 20 * HALF) @(posedge clk);  // room for a few more frames
    if (rd_cnt != N_PIX) plain_error("wrong number of memory reads");
    close_test("no output after last line");
    done = 1'b1;
  end

endmodule

`default_nettype wire

// File: verification/tb_clock.sv
`default_nettype none

module tb_clock (
  output logic clk,
  output logic rstn
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  initial begin
    rstn = 1'b0;
    repeat (3) @(posedge clk);
    rstn <= 1'b1;
  end

endmodule

`default_nettype wire

// File: verification/tb_top.sv
`default_nettype none

module tb_top import io_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF = 4;
  localparam int IMG_W = 3;
  localparam int IMG_H = 2;
  localparam word_t BASE = 32'h100;
  localparam int N_PROG = 4;
  localparam int N_PIX = IMG_W * IMG_H;
  localparam int HOST_BYTES = 4 + 4 * N_PROG;
  localparam int DUT_BYTES = 2 + 15 + 12 * N_PIX;
  localparam int TIMEOUT_CYC = (HOST_BYTES + DUT_BYTES) * 20 * HALF + 2000;

  logic clk;
  logic rstn;
  logic rxd;
  logic core_end;
  logic data_ready_io;
  word_t data_from_memory_io;
  logic txd;
  logic wr_en_instr;
  logic memread_io;
  logic core_start;
  word_t data_in_instr;
  word_t addr_in_instr;
  word_t addr_io;

  int core_delay;
  int mem_delay [N_PIX];

  word_t prog_words [N_PROG] = '{32'h00500093, 32'h00a00113, 32'h002081b3, 32'hdeadbeef};

  // red in 7:0, green in 15:8, blue in 23:16
  word_t pix_words [N_PIX] = '{
    32'hff0a0900, 32'h12c76463, 32'h8000ffc8,
    32'h0009c7ff, 32'h5aff000a, 32'hc363c864
  };
  logic [95:0] pix_lines [N_PIX] = '{
    "000 009 010\n", "099 100 199\n", "200 255 000\n",
    "255 199 009\n", "010 000 255\n", "100 200 099\n"
  };

  tb_clock i_tb_clock (.clk(clk), .rstn(rstn));

  io_top #(
    .CLK_PER_HALF_BIT(HALF), .IMG_WIDTH(IMG_W), .IMG_HEIGHT(IMG_H), .IMG_BASE(BASE)
  ) i_io_top (
    .clk(clk), .rstn(rstn), .rxd(rxd), .core_end(core_end),
    .data_ready_io(data_ready_io), .data_from_memory_io(data_from_memory_io),
    .txd(txd), .wr_en_instr(wr_en_instr), .memread_io(memread_io),
    .core_start(core_start), .data_in_instr(data_in_instr),
    .addr_in_instr(addr_in_instr), .addr_io(addr_io)
  );

  io_monitor #(
    .HALF(HALF), .IMG_BASE(BASE), .N_PROG(N_PROG), .N_PIX(N_PIX)
  ) i_io_monitor (
    .clk(clk), .rstn(rstn), .txd(txd), .wr_en_instr(wr_en_instr),
    .addr_in_instr(addr_in_instr), .data_in_instr(data_in_instr),
    .memread_io(memread_io), .addr_io(addr_io), .core_start(core_start),
    .core_end(core_end), .prog_words(prog_words), .pix_lines(pix_lines)
  );

  bind program_loader io_chk i_loader_chk (
    .clk(clk), .rstn(rstn), .pulse(wr_en_instr), .pulse_ok(load_en),
    .req(load_done), .req_ok(load_en)
  );

  bind io_control io_chk i_control_chk (
    .clk(clk), .rstn(rstn), .pulse(load_done), .pulse_ok(!core_start),
    .req(u.tx_start), .req_ok(!u.tx_busy)
  );

  // one 8N1 frame on rxd, lsb first
  task automatic send_byte(input byte_t b);
    logic [9:0] frame;
    frame = {1'b1, b, 1'b0};
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      rxd <= frame[i];
      repeat (2 * HALF - 1) @(posedge clk);
    end
  endtask

  initial begin : draw_random
    void'($urandom(64314));
    core_delay = 50 + int'($urandom % 101);
    foreach (mem_delay[i]) mem_delay[i] = 1 + int'($urandom % 8);
  end

  initial begin : host
    word_t len;
    rxd = 1'b1;
    len = 32'(4 * N_PROG);
    wait (i_io_monitor.tx_cnt >= 1);  // load sync seen
    repeat (4 * HALF) @(posedge clk);
    for (int i = 0; i < 4; i++) send_byte(len[8 * i +: 8]);
    for (int w = 0; w < N_PROG; w++) begin
      for (int i = 0; i < 4; i++) send_byte(prog_words[w][8 * i +: 8]);
    end
  end

  initial begin : core_model
    core_end = 1'b0;
    @(posedge clk);
    while (core_start !== 1'b1) @(posedge clk);
    repeat (core_delay - 1) @(posedge clk);
    core_end <= 1'b1;
  end

  initial begin : memory_model
    int idx;
    int n_rd;
    data_ready_io = 1'b0;
    data_from_memory_io = '0;
    n_rd = 0;
    forever begin
      @(posedge clk);
      if (memread_io) begin
        idx = int'((addr_io - BASE) >> 2);
        repeat (mem_delay[n_rd % N_PIX] - 1) @(posedge clk);
        data_from_memory_io <= (idx >= 0 && idx < N_PIX) ? pix_words[idx] : '0;
        data_ready_io <= 1'b1;
        @(posedge clk);
        data_ready_io <= 1'b0;
        n_rd++;
      end
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYC) @(posedge clk);
    $display("timeout: the dump did not finish within %0d cycles", TIMEOUT_CYC);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : end_of_run
    int chk_fails;
    wait (i_io_monitor.done);
    chk_fails = i_io_top.i_program_loader.i_loader_chk.fail_cnt
              + i_io_top.i_io_control.i_control_chk.fail_cnt;
    $display("summary: %0d tests, %0d with errors, %0d value errors, %0d assertion failures",
             i_io_monitor.test_cnt, i_io_monitor.bad_cnt, i_io_monitor.err_cnt, chk_fails);
    if (i_io_monitor.err_cnt == 0 && chk_fails == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/image_sender.sv
`default_nettype none

module image_sender import io_pkg::*; #(
  parameter int IMG_WIDTH = 128,
  parameter int IMG_HEIGHT = 128,
  parameter word_t IMG_BASE = '0
) (
  input logic clk,
  input logic rstn,
  input logic dump_en,
  input logic byte_ack,
  input logic data_ready_io,
  input word_t data_from_memory_io,
  output logic byte_req,
  output logic memread_io,
  output byte_t byte_out,
  output word_t addr_io
);

  // compare-and-subtract, one digit at a time
  function automatic digits3_t to_digits(input logic [9:0] v);
    digits3_t d;
    logic [9:0] r;
    d = '0;
    r = v;
    for (int k = 1; k <= 9; k++) begin
      if (r >= 10'(k * 100)) d.hundreds = 4'(k);
    end
    r = r - 10'(d.hundreds * 100);
    for (int k = 1; k <= 9; k++) begin
      if (r >= 10'(k * 10)) d.tens = 4'(k);
    end
    r = r - 10'(d.tens * 10);
    d.ones = r[3:0];
    return d;
  endfunction

  function automatic byte_t digit_char(input logic [3:0] d);
    return CHAR_ZERO + {4'b0000, d};
  endfunction

  localparam int NPIX = IMG_WIDTH * IMG_HEIGHT;
  localparam digits3_t W_DIG = to_digits(10'((IMG_WIDTH > MAX_DIM) ? MAX_DIM : IMG_WIDTH));
  localparam digits3_t H_DIG = to_digits(10'((IMG_HEIGHT > MAX_DIM) ? MAX_DIM : IMG_HEIGHT));

  typedef enum logic [2:0] {S_IDLE, S_HDR, S_READ, S_WAIT, S_PIX, S_DONE} state_t;

  state_t state;
  logic [3:0] idx;  // character within header or pixel line
  word_t pix;
  digits3_t red_d;
  digits3_t green_d;
  digits3_t blue_d;

  assign byte_req = (state == S_HDR) || (state == S_PIX);
  assign memread_io = (state == S_READ);
  assign addr_io = IMG_BASE + {pix[29:0], 2'b00};

  always_comb begin
    byte_out = CHAR_SPACE;
    if (state == S_HDR) begin
      case (idx)
        4'd0: byte_out = CHAR_P;
        4'd1: byte_out = digit_char(4'd3);
        4'd2, 4'd14: byte_out = CHAR_NEWLINE;
        4'd3: byte_out = digit_char(W_DIG.hundreds);
        4'd4: byte_out = digit_char(W_DIG.tens);
        4'd5: byte_out = digit_char(W_DIG.ones);
        4'd7: byte_out = digit_char(H_DIG.hundreds);
        4'd8: byte_out = digit_char(H_DIG.tens);
        4'd9: byte_out = digit_char(H_DIG.ones);
        4'd11: byte_out = digit_char(4'd2);  // max value 255
        4'd12, 4'd13: byte_out = digit_char(4'd5);
        default: byte_out = CHAR_SPACE;
      endcase
    end else begin
      case (idx)
        4'd0: byte_out = digit_char(red_d.hundreds);
        4'd1: byte_out = digit_char(red_d.tens);
        4'd2: byte_out = digit_char(red_d.ones);
        4'd4: byte_out = digit_char(green_d.hundreds);
        4'd5: byte_out = digit_char(green_d.tens);
        4'd6: byte_out = digit_char(green_d.ones);
        4'd8: byte_out = digit_char(blue_d.hundreds);
        4'd9: byte_out = digit_char(blue_d.tens);
        4'd10: byte_out = digit_char(blue_d.ones);
        4'd11: byte_out = CHAR_NEWLINE;
        default: byte_out = CHAR_SPACE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state <= S_IDLE;
      idx <= '0;
      pix <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (dump_en) state <= S_HDR;
        end
        S_HDR: begin
          if (byte_ack) begin
            if (idx == 4'd14) begin
              idx <= '0;
              state <= S_READ;
            end else begin
              idx <= idx + 4'd1;
            end
          end
        end
        S_READ: state <= S_WAIT;
        S_WAIT: begin
          if (data_ready_io) begin
            red_d <= to_digits({2'b00, data_from_memory_io[7:0]});
            green_d <= to_digits({2'b00, data_from_memory_io[15:8]});
            blue_d <= to_digits({2'b00, data_from_memory_io[23:16]});
            state <= S_PIX;
          end
        end
        S_PIX: begin
          if (byte_ack) begin
            if (idx != 4'd11) begin
              idx <= idx + 4'd1;
            end else if (pix == word_t'(NPIX - 1)) begin
              state <= S_DONE;  // stays here until reset
            end else begin
              pix <= pix + 1'b1;
              idx <= '0;
              state <= S_READ;
            end
          end
        end
        default: state <= S_DONE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/io_control.sv
`default_nettype none

module io_control import io_pkg::*; (
  input logic clk,
  input logic rstn,
  input logic core_end,
  input logic load_done,
  input logic byte_req,
  input byte_t byte_out,
  uart_if.ctrl u,
  output logic load_en,
  output logic dump_en,
  output logic core_start,
  output logic byte_ack
);

  typedef enum logic [2:0] {
    P_SYNC_LOAD,
    P_LOADING,
    P_SYNC_RUN,
    P_WAIT_CORE,
    P_DUMP
  } phase_t;

  phase_t phase;
  logic in_flight;  // a frame was requested and has not ended
  logic frame_done;
  logic run_idle;

  // busy rises the cycle after the start pulse
  assign frame_done = in_flight && !u.tx_start && !u.tx_busy;
  assign run_idle = (phase == P_WAIT_CORE) || (phase == P_SYNC_RUN && frame_done);
  assign dump_en = (phase == P_DUMP) || (run_idle && core_end);
  assign byte_ack = (phase == P_DUMP) && frame_done;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      phase <= P_SYNC_LOAD;
      in_flight <= 1'b0;
      u.tx_start <= 1'b0;
      load_en <= 1'b0;
      core_start <= 1'b0;
    end else begin
      u.tx_start <= 1'b0;
      if (frame_done) in_flight <= 1'b0;
      case (phase)
        P_SYNC_LOAD: begin
          if (!in_flight) begin
            u.tx_data <= SYNC_LOAD;
            u.tx_start <= 1'b1;
            in_flight <= 1'b1;
          end else if (frame_done) begin
            load_en <= 1'b1;
            phase <= P_LOADING;
          end
        end
        P_LOADING: begin
          if (load_done) begin
            load_en <= 1'b0;
            core_start <= 1'b1;  // held until reset
            u.tx_data <= SYNC_RUN;
            u.tx_start <= 1'b1;
            in_flight <= 1'b1;
            phase <= P_SYNC_RUN;
          end
        end
        P_SYNC_RUN, P_WAIT_CORE: begin
          if (run_idle && core_end) phase <= P_DUMP;
          else if (frame_done) phase <= P_WAIT_CORE;
        end
        default: begin
          if (byte_req && !in_flight && !u.tx_busy) begin
            u.tx_data <= byte_out;
            u.tx_start <= 1'b1;
            in_flight <= 1'b1;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/io_pkg.sv
`default_nettype none

package io_pkg;

  typedef logic [31:0] word_t;
  typedef logic [7:0] byte_t;

  localparam byte_t CHAR_P = 8'h50;
  localparam byte_t CHAR_ZERO = 8'h30;
  localparam byte_t CHAR_SPACE = 8'h20;
  localparam byte_t CHAR_NEWLINE = 8'h0a;

  localparam byte_t SYNC_LOAD = 8'h99; // host may send the length
  localparam byte_t SYNC_RUN = 8'haa;  // program loaded, core running

  localparam int MAX_DIM = 999; // widest side three digits can show

  typedef struct packed {
    logic [3:0] hundreds;
    logic [3:0] tens;
    logic [3:0] ones;
  } digits3_t;

endpackage

`default_nettype wire

// File: verilog/io_top.sv
`default_nettype none

module io_top #(
  parameter int CLK_PER_HALF_BIT = 217,
  parameter int IMG_WIDTH = 128,
  parameter int IMG_HEIGHT = 128,
  parameter logic [31:0] IMG_BASE = 32'h0
) (
  input logic clk,
  input logic rstn,
  input logic rxd,
  input logic core_end,
  input logic data_ready_io,
  input logic [31:0] data_from_memory_io,
  output logic txd,
  output logic wr_en_instr,
  output logic memread_io,
  output logic core_start,
  output logic [31:0] data_in_instr,
  output logic [31:0] addr_in_instr,
  output logic [31:0] addr_io
);

  uart_if u_if ();

  logic load_en;
  logic load_done;
  logic dump_en;
  logic byte_req;
  logic byte_ack;
  logic [7:0] byte_out;

  uart_tx #(.CLK_PER_HALF_BIT(CLK_PER_HALF_BIT)) i_uart_tx (
    .clk(clk), .rstn(rstn), .u(u_if.tx_side), .txd(txd)
  );

  uart_rx #(.CLK_PER_HALF_BIT(CLK_PER_HALF_BIT)) i_uart_rx (
    .clk(clk), .rstn(rstn), .rxd(rxd), .u(u_if.rx_side)
  );

  program_loader i_program_loader (
    .clk(clk), .rstn(rstn), .load_en(load_en), .u(u_if.loader),
    .load_done(load_done), .wr_en_instr(wr_en_instr),
    .addr_in_instr(addr_in_instr), .data_in_instr(data_in_instr)
  );

  image_sender #(
    .IMG_WIDTH(IMG_WIDTH), .IMG_HEIGHT(IMG_HEIGHT), .IMG_BASE(IMG_BASE)
  ) i_image_sender (
    .clk(clk), .rstn(rstn), .dump_en(dump_en), .byte_ack(byte_ack),
    .data_ready_io(data_ready_io), .data_from_memory_io(data_from_memory_io),
    .byte_req(byte_req), .memread_io(memread_io), .byte_out(byte_out), .addr_io(addr_io)
  );

  io_control i_io_control (
    .clk(clk), .rstn(rstn), .core_end(core_end), .load_done(load_done),
    .byte_req(byte_req), .byte_out(byte_out), .u(u_if.ctrl), .load_en(load_en),
    .dump_en(dump_en), .core_start(core_start), .byte_ack(byte_ack)
  );

endmodule

`default_nettype wire

// File: verilog/program_loader.sv
`default_nettype none

module program_loader import io_pkg::*; (
  input logic clk,
  input logic rstn,
  input logic load_en,
  uart_if.loader u,
  output logic load_done,
  output logic wr_en_instr,
  output word_t addr_in_instr,
  output word_t data_in_instr
);

  word_t length;       // program length in bytes
  word_t length_next;
  word_t word_buf;
  logic have_len;
  logic [1:0] byte_idx;
  logic [29:0] word_cnt;
  logic [29:0] n_words;

  assign length_next = {u.rx_data, length[31:8]};  // little endian
  assign n_words = length[31:2];  // low two bits ignored
  assign addr_in_instr = {word_cnt, 2'b00};
  assign data_in_instr = word_buf;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      have_len <= 1'b0;
      byte_idx <= '0;
      word_cnt <= '0;
      wr_en_instr <= 1'b0;
      load_done <= 1'b0;
    end else begin
      wr_en_instr <= 1'b0;
      load_done <= 1'b0;
      if (wr_en_instr) begin
        word_cnt <= word_cnt + 30'd1;
      end
      if (load_en && u.rx_valid) begin
        byte_idx <= byte_idx + 2'd1;
        if (!have_len) begin
          length <= length_next;
          if (byte_idx == 2'd3) begin
            have_len <= 1'b1;
            load_done <= (length_next[31:2] == '0);  // empty program
          end
        end else begin
          word_buf <= {u.rx_data, word_buf[31:8]};
          if (byte_idx == 2'd3) begin
            wr_en_instr <= 1'b1;
            load_done <= (word_cnt == n_words - 30'd1);
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/uart_if.sv
`default_nettype none

interface uart_if import io_pkg::*; ();

  byte_t tx_data;
  logic tx_start;  // one-cycle request
  logic tx_busy;
  byte_t rx_data;
  logic rx_valid;  // one-cycle, no back-pressure

  modport tx_side (input tx_data, tx_start, output tx_busy);
  modport rx_side (output rx_data, rx_valid);
  modport ctrl (output tx_data, tx_start, input tx_busy);
  modport loader (input rx_data, rx_valid);

endinterface

`default_nettype wire

// File: verilog/uart_rx.sv
`default_nettype none

module uart_rx import io_pkg::*; #(
  parameter int CLK_PER_HALF_BIT = 217
) (
  input logic clk,
  input logic rstn,
  input logic rxd,
  uart_if.rx_side u
);

  localparam int BIT_CYC = 2 * CLK_PER_HALF_BIT;
  localparam int CW = $clog2(BIT_CYC);

  logic [2:0] rxd_sync;  // two sync stages plus edge history
  logic busy;
  logic [CW-1:0] baud_cnt;
  logic [3:0] bit_cnt;
  byte_t shreg;
  logic sample;
  logic rx_bit;

  assign rx_bit = rxd_sync[1];
  assign sample = busy && (baud_cnt == '0);
  assign u.rx_valid = sample && (bit_cnt == 4'd9);  // stop bit, not checked
  assign u.rx_data = shreg;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rxd_sync <= 3'b111;
    end else begin
      rxd_sync <= {rxd_sync[1:0], rxd};
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      busy <= 1'b0;
      baud_cnt <= '0;
      bit_cnt <= '0;
    end else if (!busy) begin
      if (rxd_sync[2] && !rx_bit) begin
        busy <= 1'b1;
        baud_cnt <= CW'(CLK_PER_HALF_BIT - 1);  // middle of start bit
        bit_cnt <= '0;
      end
    end else if (sample) begin
      baud_cnt <= CW'(BIT_CYC - 1);
      bit_cnt <= bit_cnt + 4'd1;
      if (bit_cnt == 4'd0 && rx_bit) begin
        busy <= 1'b0;  // glitch, line back high
      end else if (bit_cnt == 4'd9) begin
        busy <= 1'b0;
      end else if (bit_cnt != 4'd0) begin
        shreg <= {rx_bit, shreg[7:1]};
      end
    end else begin
      baud_cnt <= baud_cnt - 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: verilog/uart_tx.sv
`default_nettype none

module uart_tx #(
  parameter int CLK_PER_HALF_BIT = 217
) (
  input logic clk,
  input logic rstn,
  uart_if.tx_side u,
  output logic txd
);

  localparam int BIT_CYC = 2 * CLK_PER_HALF_BIT;
  localparam int CW = $clog2(BIT_CYC);

  logic [CW-1:0] baud_cnt;
  logic [3:0] bit_cnt;  // 0 is the start bit
  logic [8:0] shreg;    // data bits, then stop bit
  logic busy;

  assign u.tx_busy = busy;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      busy <= 1'b0;
      baud_cnt <= '0;
      bit_cnt <= '0;
      txd <= 1'b1;
    end else if (!busy) begin
      if (u.tx_start) begin
        busy <= 1'b1;
        baud_cnt <= '0;
        bit_cnt <= '0;
        shreg <= {1'b1, u.tx_data};
        txd <= 1'b0;
      end
    end else if (baud_cnt == CW'(BIT_CYC - 1)) begin
      baud_cnt <= '0;
      if (bit_cnt == 4'd9) begin
        busy <= 1'b0;  // end of stop bit
        txd <= 1'b1;
      end else begin
        bit_cnt <= bit_cnt + 4'd1;
        txd <= shreg[0];  // lsb first
        shreg <= {1'b1, shreg[8:1]};
      end
    end else begin
      baud_cnt <= baud_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire
